// File: enigma.f
+incdir+rtl
rtl/enigma_pkg.sv
rtl/enigma_cmd_reg.sv
rtl/rotor_a_tables.sv
rtl/cipher_state.sv
rtl/cipher_datapath.sv
rtl/enigma.sv
tb/tb_clkgen.sv
tb/tb_enigma.sv

// File: run.sh
#!/bin/sh
# compile and run the enigma testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_enigma -f enigma.f -o sim_enigma

# the simulator exits nonzero on a failure, the log decides
./obj_dir/sim_enigma > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
echo "simulation ended without a result"
exit 1

// File: tb/tb_enigma.sv
/*
  enigma testbench
  directed tests checked against a reference model of the rotor cipher
*/
`timescale 1ns/1ns
`include "enigma_cfg.svh"

module tb_enigma;

  localparam int LAT             = `ENIGMA_LATENCY;
  localparam int DEPTH           = `ENIGMA_TBL_DEPTH;
  localparam int N_SYM           = 32;
  localparam int CLK_PERIOD_NS   = 4;
  localparam int EXPECTED_CYCLES = 500;
  localparam int TIMEOUT_NS      = EXPECTED_CYCLES * CLK_PERIOD_NS * 10;  // 20 us

  logic                    clk;
  logic                    srst_n;
  logic                    load;
  logic                    encrypt;
  enigma_pkg::crypt_mode_e crypt_mode;
  enigma_pkg::table_idx_e  table_idx;
  enigma_pkg::sym_t        code_in;
  enigma_pkg::sym_t        code_out;
  logic                    code_valid;

  tb_clkgen u_clkgen (.clk(clk));

  enigma uut (
    .clk        (clk),
    .srst_n     (srst_n),
    .load       (load),
    .encrypt    (encrypt),
    .crypt_mode (crypt_mode),
    .table_idx  (table_idx),
    .code_in    (code_in),
    .code_out   (code_out),
    .code_valid (code_valid)
  );

  // ====================
  // stimulus and model state
  // ====================
  integer           seed = 32'h8739;
  enigma_pkg::sym_t perm [DEPTH];   // rotor a permutation
  enigma_pkg::sym_t pt [N_SYM];     // plaintext
  enigma_pkg::sym_t ct [N_SYM];     // ciphertext from the burst test
  enigma_pkg::sym_t got_q [$];      // code_out on every valid pulse

  enigma_pkg::sym_t     m_fwd [DEPTH];
  enigma_pkg::sym_t     m_inv [DEPTH];
  enigma_pkg::sym_t     m_count;
  enigma_pkg::sym_t     m_lfsr;
  enigma_pkg::sw_mode_e m_mode;

  logic             pipe_valid [LAT];  // expected outputs still in flight
  enigma_pkg::sym_t pipe_code [LAT];
  enigma_pkg::sym_t exp_out;            // code_out holds between pulses

  // ====================
  // compare tasks
  // ====================
  task automatic check_code(input enigma_pkg::sym_t got, input enigma_pkg::sym_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "code mismatch");
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "valid mismatch");
    end
  endtask

  // ====================
  // reference model
  // ====================
  // out bit j taken from in bit src, inverted only in sw_invert
  function automatic enigma_pkg::sym_t ref_switch(input enigma_pkg::sw_mode_e m,
                                                  input enigma_pkg::sym_t d);
    enigma_pkg::sym_t r;
    int               src;
    for (int j = 0; j < 6; j++) begin
      case (m)
        enigma_pkg::sw_reverse:     src = 5 - j;
        enigma_pkg::sw_swap_pairs:  src = j ^ 1;
        enigma_pkg::sw_swap_halves: src = (j + 3) % 6;
        default:                    src = j;
      endcase
      r[j] = (m == enigma_pkg::sw_invert) ? ~d[src] : d[src];
    end
    return r;
  endfunction

  task automatic model_load(input enigma_pkg::sym_t w);
    for (int i = 0; i < DEPTH - 1; i++) begin
      m_fwd[i] = m_fwd[i+1];
    end
    m_fwd[DEPTH-1] = w;
    m_inv[w]       = m_count;  // position before the step
    m_count        = m_count + 6'd1;
  endtask

  task automatic model_pass(input enigma_pkg::sym_t x, input logic dec,
                            output enigma_pkg::sym_t y);
    enigma_pkg::sym_t a, f, g, h, k;
    logic [1:0]       stp;
    a = x + m_count;
    f = m_fwd[a];
    g = ref_switch(m_mode, f);
    h = g ^ m_lfsr;                // turnaround
    k = ref_switch(m_mode, h);
    y = m_inv[k] - m_count;
    stp     = dec ? k[1:0] : f[1:0];
    m_count = m_count + {4'd0, stp};
    m_mode  = enigma_pkg::sw_mode_e'(dec ? h[1:0] : g[1:0]);
    m_lfsr  = {m_lfsr[4:0], m_lfsr[5] ^ m_lfsr[4]};
  endtask

  // ====================
  // cycle driver
  // ====================
  // check the edge just passed, then drive the next cycle
  task automatic step(input logic ld, input logic enc, input enigma_pkg::crypt_mode_e cm,
                      input enigma_pkg::table_idx_e ti, input enigma_pkg::sym_t code);
    enigma_pkg::sym_t y;
    @(posedge clk);
    #1;
    if (pipe_valid[LAT-1]) exp_out = pipe_code[LAT-1];
    check_valid(code_valid, pipe_valid[LAT-1], "code_valid");
    check_code(code_out, exp_out, "code_out");
    if (pipe_valid[LAT-1]) got_q.push_back(code_out);
    for (int i = LAT - 1; i > 0; i--) begin
      pipe_valid[i] = pipe_valid[i-1];
      pipe_code[i]  = pipe_code[i-1];
    end
    pipe_valid[0] = 1'b0;
    pipe_code[0]  = '0;
    load       = ld;
    encrypt    = enc;
    crypt_mode = cm;
    table_idx  = ti;
    code_in    = code;
    if (ld && ti == enigma_pkg::table_rotor_a) begin
      model_load(code);
    end else if (enc && !ld) begin  // foreign loads fall through untouched
      model_pass(code, cm == enigma_pkg::crypt_decrypt, y);
      pipe_valid[0] = 1'b1;
      pipe_code[0]  = y;
    end
  endtask

  task automatic idle();
    step(1'b0, 1'b0, enigma_pkg::crypt_encrypt, enigma_pkg::table_rotor_a, '0);
  endtask

  task automatic drain();
    repeat (LAT) idle();  // let the last symbols out
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    srst_n  = 1'b0;
    load    = 1'b0;
    encrypt = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    srst_n  = 1'b1;
    for (int i = 0; i < LAT; i++) begin
      pipe_valid[i] = 1'b0;
      pipe_code[i]  = '0;
    end
    exp_out = '0;
    m_count = '0;      // tables survive reset
    m_mode  = enigma_pkg::sw_invert;
    m_lfsr  = `ENIGMA_LFSR_SEED;
  endtask

  task automatic load_rotor_a();
    for (int i = 0; i < DEPTH; i++) begin
      step(1'b1, 1'b0, enigma_pkg::crypt_encrypt, enigma_pkg::table_rotor_a, perm[i]);
    end
  endtask

  task automatic send_block(input enigma_pkg::crypt_mode_e cm, input int max_gap);
    int gap;
    got_q.delete();
    for (int i = 0; i < N_SYM; i++) begin
      gap = (max_gap > 0) ? ({$random(seed)} % (max_gap + 1)) : 0;
      repeat (gap) idle();
      step(1'b0, 1'b1, cm, enigma_pkg::table_rotor_a,
           (cm == enigma_pkg::crypt_decrypt) ? ct[i] : pt[i]);
    end
    drain();
  endtask

  // ====================
  // directed tests
  // ====================
  task automatic test_idle_after_reset();
    apply_reset();
    repeat (10) idle();  // step checks valid low, out 0
  endtask

  task automatic test_encrypt_burst();
    load_rotor_a();
    send_block(enigma_pkg::crypt_encrypt, 0);
    for (int i = 0; i < N_SYM; i++) ct[i] = got_q[i];
  endtask

  task automatic test_decrypt_roundtrip();
    apply_reset();
    load_rotor_a();
    send_block(enigma_pkg::crypt_decrypt, 0);
    for (int i = 0; i < N_SYM; i++) check_code(got_q[i], pt[i], "decrypted symbol");
  endtask

  task automatic test_foreign_loads();
    enigma_pkg::table_idx_e ti;
    apply_reset();
    load_rotor_a();
    for (int i = 0; i < DEPTH; i++) begin
      ti = (i % 2) ? enigma_pkg::table_plugboard : enigma_pkg::table_rotor_b;
      step(1'b1, i[1], enigma_pkg::crypt_encrypt, ti, enigma_pkg::sym_t'($random(seed)));
      if (i >= LAT) begin  // last rotor a loads have landed by now
        check_code(uut.u_state.count, m_count, "rotor count during foreign loads");
      end
    end
    drain();
    check_code(uut.u_state.count, m_count, "rotor count after foreign loads");
    send_block(enigma_pkg::crypt_encrypt, 0);
    for (int i = 0; i < N_SYM; i++) check_code(got_q[i], ct[i], "cipher after foreign loads");
  endtask

  task automatic test_gapped_symbols();
    apply_reset();
    load_rotor_a();
    send_block(enigma_pkg::crypt_encrypt, 3);  // 0..3 idle cycles before each
    for (int i = 0; i < N_SYM; i++) check_code(got_q[i], ct[i], "cipher with gaps");
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    srst_n     = 1'b0;
    load       = 1'b0;
    encrypt    = 1'b0;
    crypt_mode = enigma_pkg::crypt_encrypt;
    table_idx  = enigma_pkg::table_rotor_a;
    code_in    = '0;
    for (int i = 0; i < DEPTH; i++) perm[i] = enigma_pkg::sym_t'(i);
    for (int i = DEPTH - 1; i > 0; i--) begin  // fisher-yates shuffle
      int j;
      enigma_pkg::sym_t t;
      j       = {$random(seed)} % (i + 1);
      t       = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
    for (int i = 0; i < N_SYM; i++) pt[i] = enigma_pkg::sym_t'($random(seed));

    test_idle_after_reset();
    test_encrypt_burst();
    test_decrypt_roundtrip();
    test_foreign_loads();
    test_gapped_symbols();

    $display("TEST RESULT: PASS");
    $finish;
  end

  // watchdog, ten times the expected run
  initial begin
    #TIMEOUT_NS;
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// File: tb/tb_clkgen.sv
/*
  testbench clock source
  free running clk, 4 ns period
*/
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk
);

  localparam int HALF_NS = 2;  // half of the 4 ns period

  initial clk = 1'b0;
  always #HALF_NS clk = ~clk;

endmodule

// File: rtl/enigma.sv
/*
  enigma rotor cipher top level
  input register, rotor a tables, cipher state and the datapath
*/
`timescale 1ns/1ns

module enigma (
  input  logic                    clk,
  input  logic                    srst_n,      // sync, active low
  input  logic                    load,        // level, table load
  input  logic                    encrypt,     // level, one symbol per cycle
  input  enigma_pkg::crypt_mode_e crypt_mode,
  input  enigma_pkg::table_idx_e  table_idx,
  input  enigma_pkg::sym_t        code_in,
  output enigma_pkg::sym_t        code_out,
  output logic                    code_valid
);

  // ====================
  // internal wires
  // ====================
  logic                    rotor_load;
  logic                    sym_valid;
  enigma_pkg::sym_t        sym_in;
  enigma_pkg::crypt_mode_e mode_reg;

  enigma_pkg::sym_t        fwd_addr, inv_addr;
  enigma_pkg::sym_t        fwd_word, inv_word;

  enigma_pkg::sym_t        count;
  enigma_pkg::sw_mode_e    sw_mode;
  enigma_pkg::sym_t        whiten;
  logic [1:0]              count_step;
  enigma_pkg::sw_mode_e    mode_next;

  // ====================
  // blocks
  // ====================
  enigma_cmd_reg u_cmd_reg (
    .clk        (clk),
    .srst_n     (srst_n),
    .load       (load),
    .encrypt    (encrypt),
    .crypt_mode (crypt_mode),
    .table_idx  (table_idx),
    .code_in    (code_in),
    .rotor_load (rotor_load),
    .sym_valid  (sym_valid),
    .sym_in     (sym_in),
    .mode_reg   (mode_reg)
  );

  rotor_a_tables u_rotor_a (
    .clk        (clk),
    .rotor_load (rotor_load),
    .load_word  (sym_in),     // loaded word arrives on the code bus
    .load_count (count),      // count before its increment
    .fwd_addr   (fwd_addr),
    .inv_addr   (inv_addr),
    .fwd_word   (fwd_word),
    .inv_word   (inv_word)
  );

  cipher_state u_state (
    .clk        (clk),
    .srst_n     (srst_n),
    .rotor_load (rotor_load),
    .sym_valid  (sym_valid),
    .count_step (count_step),
    .mode_next  (mode_next),
    .count      (count),
    .sw_mode    (sw_mode),
    .whiten     (whiten)
  );

  cipher_datapath u_datapath (
    .clk        (clk),
    .srst_n     (srst_n),
    .sym_in     (sym_in),
    .mode_reg   (mode_reg),
    .sym_valid  (sym_valid),
    .count      (count),
    .sw_mode    (sw_mode),
    .whiten     (whiten),
    .fwd_word   (fwd_word),
    .inv_word   (inv_word),
    .fwd_addr   (fwd_addr),
    .inv_addr   (inv_addr),
    .count_step (count_step),
    .mode_next  (mode_next),
    .code_out   (code_out),
    .code_valid (code_valid)
  );

endmodule

// File: rtl/cipher_datapath.sv
/*
  enigma cipher pass
  rotor a, bit switch, whitening turnaround and back, then out reg
*/
`timescale 1ns/1ns

module cipher_datapath (
  input  logic                    clk,
  input  logic                    srst_n,
  input  enigma_pkg::sym_t        sym_in,
  input  enigma_pkg::crypt_mode_e mode_reg,
  input  logic                    sym_valid,
  input  enigma_pkg::sym_t        count,
  input  enigma_pkg::sw_mode_e    sw_mode,
  input  enigma_pkg::sym_t        whiten,
  input  enigma_pkg::sym_t        fwd_word,
  input  enigma_pkg::sym_t        inv_word,
  output enigma_pkg::sym_t        fwd_addr,
  output enigma_pkg::sym_t        inv_addr,
  output logic [1:0]              count_step,
  output enigma_pkg::sw_mode_e    mode_next,
  output enigma_pkg::sym_t        code_out,
  output logic                    code_valid
);

  enigma_pkg::sym_t f_sym;   // after forward rotor
  enigma_pkg::sym_t g_sym;   // after first switch
  enigma_pkg::sym_t h_sym;   // after whitening
  enigma_pkg::sym_t k_sym;   // after second switch
  enigma_pkg::sym_t y_sym;   // after inverse rotor
  logic             is_dec;

  // ====================
  // bit switch
  // ====================
  // same network both ways, every mode is an involution
  function automatic enigma_pkg::sym_t bit_switch(
    input enigma_pkg::sw_mode_e mode,
    input enigma_pkg::sym_t     d
  );
    case (mode)
      enigma_pkg::sw_invert:      bit_switch = ~d;
      enigma_pkg::sw_reverse:     bit_switch = {d[0], d[1], d[2], d[3], d[4], d[5]};
      enigma_pkg::sw_swap_pairs:  bit_switch = {d[4], d[5], d[2], d[3], d[0], d[1]};
      enigma_pkg::sw_swap_halves: bit_switch = {d[2], d[1], d[0], d[5], d[4], d[3]};
      default:                    bit_switch = d;
    endcase
  endfunction

  // ====================
  // one pass
  // ====================
  assign fwd_addr = sym_in + count;              // rotate into rotor a
  assign f_sym    = fwd_word;
  assign g_sym    = bit_switch(sw_mode, f_sym);
  assign h_sym    = g_sym ^ whiten;              // turnaround
  assign k_sym    = bit_switch(sw_mode, h_sym);
  assign inv_addr = k_sym;
  assign y_sym    = inv_word - count;            // rotate back out

  // decrypt sees the encrypt path mirrored, so f<->k and g<->h
  assign is_dec = (mode_reg == enigma_pkg::crypt_decrypt);

  // state steering, identical values on both sides of the cipher
  assign count_step = is_dec ? k_sym[1:0] : f_sym[1:0];
  assign mode_next  = enigma_pkg::sw_mode_e'(is_dec ? h_sym[1:0] : g_sym[1:0]);

  // ====================
  // output register
  // ====================
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      code_out   <= '0;
      code_valid <= 1'b0;
    end else begin
      code_valid <= sym_valid;   // one-cycle pulse per symbol
      if (sym_valid) begin
        code_out <= y_sym;       // held between symbols
      end
    end
  end

endmodule

// File: rtl/cipher_state.sv
/*
  cipher state registers
  rotor a shift count, bit switch mode and whitening lfsr
*/
`timescale 1ns/1ns
`include "enigma_cfg.svh"

module cipher_state (
  input  logic                 clk,
  input  logic                 srst_n,
  input  logic                 rotor_load,
  input  logic                 sym_valid,
  input  logic [1:0]           count_step,  // from the pass
  input  enigma_pkg::sw_mode_e mode_next,
  output enigma_pkg::sym_t     count,
  output enigma_pkg::sw_mode_e sw_mode,
  output enigma_pkg::sym_t     whiten
);

  enigma_pkg::sym_t count_nxt;
  enigma_pkg::sym_t lfsr_nxt;

  // ====================
  // shift count
  // ====================
  // rotor_load and sym_valid never overlap
  always_comb begin
    count_nxt = count;
    if (rotor_load) begin
      count_nxt = count + 1'b1;             // one step per loaded word
    end else if (sym_valid) begin
      count_nxt = count + {4'd0, count_step};  // wraps mod 64
    end
  end

  // taps at bits 5 and 4
  assign lfsr_nxt = {whiten[4:0], whiten[4] ^ whiten[5]};

  // ====================
  // registers
  // ====================
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      count   <= '0;
      sw_mode <= enigma_pkg::sw_invert;
      whiten  <= `ENIGMA_LFSR_SEED;
    end else begin
      count <= count_nxt;
      if (sym_valid) begin
        sw_mode <= mode_next;  // steered by the symbol just passed
        whiten  <= lfsr_nxt;
      end
    end
  end

endmodule

// File: rtl/rotor_a_tables.sv
/*
  rotor a forward and inverse tables
  forward table is shift loaded, inverse written at the loaded word
*/
`timescale 1ns/1ns
`include "enigma_cfg.svh"

module rotor_a_tables (
  input  logic             clk,
  input  logic             rotor_load,
  input  enigma_pkg::sym_t load_word,
  input  enigma_pkg::sym_t load_count,  // index of the word being loaded
  input  enigma_pkg::sym_t fwd_addr,
  input  enigma_pkg::sym_t inv_addr,
  output enigma_pkg::sym_t fwd_word,
  output enigma_pkg::sym_t inv_word
);

  enigma_pkg::sym_t fwd_mem [`ENIGMA_TBL_DEPTH];
  enigma_pkg::sym_t inv_mem [`ENIGMA_TBL_DEPTH];

  // ====================
  // forward table
  // ====================
  // new word at the top, rest moves down one
  // after a full load entry i holds the i-th word
  always_ff @(posedge clk) begin
    if (rotor_load) begin
      fwd_mem[`ENIGMA_TBL_DEPTH-1] <= load_word;
      for (int i = 0; i < `ENIGMA_TBL_DEPTH-1; i++) begin
        fwd_mem[i] <= fwd_mem[i+1];
      end
    end
  end

  // ====================
  // inverse table
  // ====================
  // word -> position, so inv[fwd[i]] == i once loaded
  always_ff @(posedge clk) begin
    if (rotor_load) begin
      inv_mem[load_word] <= load_count;
    end
  end

  // async reads, both used in the same pass
  assign fwd_word = fwd_mem[fwd_addr];
  assign inv_word = inv_mem[inv_addr];

endmodule

// File: rtl/enigma_cmd_reg.sv
/*
  enigma input register
  samples the pins and decodes load and encrypt strobes
*/
`timescale 1ns/1ns

module enigma_cmd_reg (
  input  logic                    clk,
  input  logic                    srst_n,
  input  logic                    load,
  input  logic                    encrypt,
  input  enigma_pkg::crypt_mode_e crypt_mode,
  input  enigma_pkg::table_idx_e  table_idx,
  input  enigma_pkg::sym_t        code_in,
  output logic                    rotor_load,  // write strobe for rotor a
  output logic                    sym_valid,   // symbol in sym_in this cycle
  output enigma_pkg::sym_t        sym_in,
  output enigma_pkg::crypt_mode_e mode_reg
);

  logic rotor_a_sel;
  logic sym_go;

  // plugboard and rotor b loads fall out here
  assign rotor_a_sel = load && (table_idx == enigma_pkg::table_rotor_a);
  assign sym_go      = encrypt && !load;  // load wins over encrypt

  // ====================
  // strobes
  // ====================
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      rotor_load <= 1'b0;
      sym_valid  <= 1'b0;
    end else begin
      rotor_load <= rotor_a_sel;
      sym_valid  <= sym_go;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    sym_in   <= code_in;     // code word or table word
    mode_reg <= crypt_mode;
  end

endmodule

// File: rtl/enigma_pkg.sv
/*
  enigma shared types
  symbol type and the enums for pins and bit-switch modes
*/
`include "enigma_cfg.svh"

package enigma_pkg;

  typedef logic [`ENIGMA_SYM_W-1:0] sym_t;  // code word, table entry, count, lfsr

  typedef enum logic {
    crypt_encrypt = 1'b0,
    crypt_decrypt = 1'b1
  } crypt_mode_e;

  // which table a load goes to, only rotor a is kept
  typedef enum logic [1:0] {
    table_rotor_a   = 2'd0,
    table_plugboard = 2'd1,
    table_rotor_b   = 2'd2
  } table_idx_e;

  // bit switch modes, each one undoes itself
  typedef enum logic [1:0] {
    sw_invert      = 2'd0,  // ~x
    sw_reverse     = 2'd1,  // bit order flipped
    sw_swap_pairs  = 2'd2,  // 4,5,2,3,0,1
    sw_swap_halves = 2'd3   // 2,1,0,5,4,3
  } sw_mode_e;

endpackage

// File: rtl/enigma_cfg.svh
/*
  enigma core configuration
  symbol width, table depth, whitening seed and pass latency
*/
`ifndef ENIGMA_CFG_SVH
`define ENIGMA_CFG_SVH

// ====================
// symbol and table size
// ====================
`define ENIGMA_SYM_W      6     // bits per code word
`define ENIGMA_TBL_DEPTH  64    // rotor table entries, 2**sym_w

// ====================
// state and timing
// ====================
`define ENIGMA_LFSR_SEED  6'b000001  // whitening lfsr after reset
`define ENIGMA_LATENCY    2          // pin to code_out, in cycles

`endif
